/* Bender.yml */
package:
  name: tk2000_glue

sources:
  - core_glue_pkg.sv
  - reset_sequencer.sv
  - joystick_key_merge.sv
  - track_change_detect.sv
  - sector_fetch_sequencer.sv
  - tk2000_glue_top.sv
  - target: test
    files:
      - tb_tk2000_glue_asserts.sv
      - tb_tk2000_glue.sv

/* core_glue_pkg.sv */
// Shared widths, constants and bus types for the home-computer glue logic
// Used by the reset, keyboard merge and floppy track loader blocks
package core_glue_pkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////

	// Drive head track number
	localparam int unsigned TRACK_W      = 6;
	// SD block address
	localparam int unsigned LBA_W        = 32;
	localparam int unsigned RAM_ADDR_W   = 16;
	localparam int unsigned RAM_DATA_W   = 8;
	// Sector counter within one track
	localparam int unsigned SECTOR_IDX_W = 4;

	// Warm-start vector location, zeroed during reset hold
	localparam logic [RAM_ADDR_W-1:0] RAM_CLEAR_ADDR = 16'h03F4;

	////////////////////////////////////////
	// Bus types
	////////////////////////////////////////

	// One RAM request, 25 bits
	typedef struct packed {
		logic [RAM_ADDR_W-1:0] addr;
		logic [RAM_DATA_W-1:0] wdata;
		logic                  we;
	} ram_port_t;

	// SD read request, level held until last ack
	typedef struct packed {
		logic             rd;
		logic [LBA_W-1:0] lba;
	} sd_req_t;

	// Joystick state, all active high
	// Bit 0 is right, as on the host joystick word
	typedef struct packed {
		logic fire2;
		logic fire1;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

	typedef logic [5:0] kbd_cols_t;
	typedef logic [7:0] kbd_rows_t;

	// Track request from detector to fetcher
	typedef struct packed {
		logic [TRACK_W-1:0] track;
	} track_req_t;

endpackage

/* joystick_key_merge.sv */
// Joystick merge into the scanned keyboard columns
// Directions answer on column 0, fire buttons on column 4
module joystick_key_merge (
	input  logic                     CLK_VIDEO,
	input  logic                     reset_s,
	input  core_glue_pkg::kbd_rows_t kbd_rows_i,
	input  core_glue_pkg::kbd_cols_t kbd_cols_i,
	input  core_glue_pkg::joy_t      joy_i,
	output core_glue_pkg::kbd_cols_t kbd_cols_o
);

	import core_glue_pkg::*;

	kbd_cols_t cols_next;
	// Direction hit on the selected row
	logic      dir_hit;
	// Either fire button on row 7
	logic      fire_hit;

	////////////////////////////////////////
	// Merge rule
	////////////////////////////////////////

	// Row 6 up, row 5 down, row 4 right, row 3 left
	assign dir_hit = (kbd_rows_i[6] & joy_i.up)
		| (kbd_rows_i[5] & joy_i.down)
		| (kbd_rows_i[4] & joy_i.right)
		| (kbd_rows_i[3] & joy_i.left);

	assign fire_hit = kbd_rows_i[7] & (joy_i.fire1 | joy_i.fire2);

	always_comb begin
		cols_next = kbd_cols_i;
		if (dir_hit) begin
			cols_next[0] = 1'b1;
		end
		if (fire_hit) begin
			cols_next[4] = 1'b1;
		end
	end

	// Registered column value back to the CPU
	always_ff @(posedge CLK_VIDEO) begin
		if (reset_s) begin
			kbd_cols_o <= '0;
		end else begin
			kbd_cols_o <= cols_next;
		end
	end

endmodule

/* project.f */
core_glue_pkg.sv
reset_sequencer.sv
joystick_key_merge.sv
track_change_detect.sv
sector_fetch_sequencer.sv
tk2000_glue_top.sv
tb_tk2000_glue_asserts.sv
tb_tk2000_glue.sv

/* reset_sequencer.sv */
// Power-on reset sequencer with a counted hold after any reset request
// Forces a zero write to the warm-start vector while the hold is active
module reset_sequencer #(
	parameter int unsigned HOLD_BITS = 23
) (
	input  logic                     CLK_VIDEO,
	input  logic                     reset_s,
	input  logic                     user_reset_i,
	input  core_glue_pkg::ram_port_t cpu_ram_i,
	output core_glue_pkg::ram_port_t ram_o,
	output logic                     por_hold_o,
	output logic                     cpu_reset_o
);

	import core_glue_pkg::*;

	// Hold counter, top bit marks end of hold
	logic [HOLD_BITS-1:0] hold_cnt;
	logic                 por_hold;
	// Any source asking for a reset
	logic                 reset_req;

	assign reset_req = reset_s | user_reset_i;

	////////////////////////////////////////
	// Hold counter
	////////////////////////////////////////

	// reset_s is itself a request, so it also restarts the hold
	always_ff @(posedge CLK_VIDEO) begin
		if (reset_req) begin
			hold_cnt <= '0;
			por_hold <= 1'b1;
		end else if (por_hold) begin
			// Release one edge after the top bit sets
			if (hold_cnt[HOLD_BITS-1]) begin
				por_hold <= 1'b0;
			end else begin
				hold_cnt <= hold_cnt + 1'b1;
			end
		end
	end

	// CPU reset follows all sources by one cycle
	always_ff @(posedge CLK_VIDEO) begin
		cpu_reset_o <= reset_req | por_hold;
	end

	assign por_hold_o = por_hold;

	////////////////////////////////////////
	// RAM clear override
	////////////////////////////////////////

	// While held, write zero to the warm-start vector
	// so the ROM takes a cold start afterwards
	always_comb begin
		if (por_hold) begin
			ram_o.addr  = RAM_CLEAR_ADDR;
			ram_o.wdata = '0;
			ram_o.we    = 1'b1;
		end else begin
			// Normal CPU access
			ram_o = cpu_ram_i;
		end
	end

endmodule

/* sector_fetch_sequencer.sv */
// Sector fetch sequencer, reads one whole track of SD blocks
// Holds the CPU in wait until the last sector has been taken
module sector_fetch_sequencer #(
	parameter int unsigned SECTORS_PER_TRACK = 13
) (
	input  logic                                   CLK_VIDEO,
	input  logic                                   reset_s,
	input  logic                                   load_req_i,
	input  core_glue_pkg::track_req_t              req_i,
	input  logic                                   sd_ack_i,
	output logic                                   load_ack_o,
	output core_glue_pkg::sd_req_t                 sd_req_o,
	output logic [core_glue_pkg::SECTOR_IDX_W-1:0] sector_index_o,
	output logic                                   cpu_wait_o
);

	import core_glue_pkg::*;

	localparam logic [SECTOR_IDX_W-1:0] LAST_SECTOR = SECTOR_IDX_W'(SECTORS_PER_TRACK - 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_DONE
	} fetch_state_t;

	fetch_state_t     state;
	logic             rd;
	logic [LBA_W-1:0] lba;
	logic             ack_q;
	logic             ack_rise;
	logic             ack_fall;

	////////////////////////////////////////
	// SD acknowledge edges
	////////////////////////////////////////

	always_ff @(posedge CLK_VIDEO) begin
		if (reset_s) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= sd_ack_i;
		end
	end

	assign ack_rise = sd_ack_i & ~ack_q;
	assign ack_fall = ~sd_ack_i & ack_q;

	////////////////////////////////////////
	// Track load FSM
	////////////////////////////////////////

	always_ff @(posedge CLK_VIDEO) begin
		if (reset_s) begin
			state          <= ST_IDLE;
			rd             <= 1'b0;
			sector_index_o <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (load_req_i) begin
						// First block of the track
						sector_index_o <= '0;
						rd             <= 1'b1;
						state          <= ST_LOAD;
					end
				end
				ST_LOAD: begin
					// Last sector taken, stop asking
					if (ack_rise && sector_index_o == LAST_SECTOR) begin
						rd <= 1'b0;
					end
					if (ack_fall) begin
						sector_index_o <= sector_index_o + 1'b1;
						// Fall after rd dropped ends the track
						if (!rd) begin
							state <= ST_DONE;
						end
					end
				end
				ST_DONE: begin
					// Return to zero once request drops
					if (!load_req_i) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Block address, payload only
	always_ff @(posedge CLK_VIDEO) begin
		if (state == ST_IDLE && load_req_i) begin
			lba <= LBA_W'(SECTORS_PER_TRACK) * LBA_W'(req_i.track);
		end else if (state == ST_LOAD && ack_rise) begin
			// Current block taken, move on
			lba <= lba + 1'b1;
		end
	end

	assign sd_req_o.rd  = rd;
	assign sd_req_o.lba = lba;
	// Wait falls in the cycle load_ack rises
	assign cpu_wait_o   = (state == ST_LOAD);
	assign load_ack_o   = (state == ST_DONE);

endmodule

/* tb_tk2000_glue.sv */
// Directed testbench for the home-computer glue top
// Covers reset hold, RAM clear, joystick merge and track loading
module tb_tk2000_glue;

	timeunit 1ns;
	timeprecision 100ps;

	import core_glue_pkg::*;

	localparam int unsigned HOLD_BITS         = 4;
	localparam int unsigned SECTORS_PER_TRACK = 13;
	// Hold falls this many edges after the last request
	localparam int HOLD_EDGES     = (1 << (HOLD_BITS - 1)) + 1;
	// Well above the length of the whole test sequence
	localparam int TIMEOUT_CYCLES = 2000;
	localparam ram_port_t CLEAR_REQ = '{addr: RAM_CLEAR_ADDR, wdata: 8'h00, we: 1'b1};

	logic                    CLK_VIDEO;
	logic                    reset_s;
	logic                    user_reset_i;
	ram_port_t               cpu_ram_i;
	kbd_rows_t               kbd_rows_i;
	kbd_cols_t               kbd_cols_i;
	joy_t                    joy_i;
	logic [TRACK_W-1:0]      track_i;
	logic                    img_mounted_i;
	logic                    image_present_i;
	logic                    sd_ack_i;
	ram_port_t               ram_o;
	logic                    por_hold_o;
	logic                    cpu_reset_o;
	kbd_cols_t               kbd_cols_o;
	sd_req_t                 sd_req_o;
	logic [SECTOR_IDX_W-1:0] sector_index_o;
	logic                    cpu_wait_o;

	integer seed;
	int     cycle_count;
	int     assert_errors;

	tk2000_glue_top #(
		.HOLD_BITS         (HOLD_BITS),
		.SECTORS_PER_TRACK (SECTORS_PER_TRACK)
	) u_tk2000_glue_top (
		.CLK_VIDEO       (CLK_VIDEO),
		.reset_s         (reset_s),
		.user_reset_i    (user_reset_i),
		.cpu_ram_i       (cpu_ram_i),
		.kbd_rows_i      (kbd_rows_i),
		.kbd_cols_i      (kbd_cols_i),
		.joy_i           (joy_i),
		.track_i         (track_i),
		.img_mounted_i   (img_mounted_i),
		.image_present_i (image_present_i),
		.sd_ack_i        (sd_ack_i),
		.ram_o           (ram_o),
		.por_hold_o      (por_hold_o),
		.cpu_reset_o     (cpu_reset_o),
		.kbd_cols_o      (kbd_cols_o),
		.sd_req_o        (sd_req_o),
		.sector_index_o  (sector_index_o),
		.cpu_wait_o      (cpu_wait_o)
	);

	////////////////////////////////////////
	// Clock and run limit
	////////////////////////////////////////

	initial CLK_VIDEO = 1'b0;
	always #2 CLK_VIDEO = ~CLK_VIDEO;

	// Bound assertion failures stop the run one edge later
	always @(posedge CLK_VIDEO) begin
		cycle_count = cycle_count + 1;
		if (u_tk2000_glue_top.u_glue_asserts.fail_count != 0) begin
			fail_now("A bound assertion failed during the run");
		end else if (cycle_count >= TIMEOUT_CYCLES) begin
			fail_now($sformatf("Timeout after %0d clock cycles", TIMEOUT_CYCLES));
		end
	end

	task automatic fail_now(input string reason);
		$display("%s", reason);
		$display("SIMULATION FAILED");
		$fatal(1, "Run stopped on first error");
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic step_cycle();
		@(posedge CLK_VIDEO);
		#1;
	endtask

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////

	task automatic check_ram(input ram_port_t got, input ram_port_t exp, input string name);
		if (got !== exp) begin
			fail_now($sformatf("FAILED %s: got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_sd(input sd_req_t got, input sd_req_t exp, input string name);
		if (got !== exp) begin
			fail_now($sformatf("FAILED %s: got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_cols(input kbd_cols_t got, input kbd_cols_t exp, input string name);
		if (got !== exp) begin
			fail_now($sformatf("FAILED %s: got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_index(input logic [SECTOR_IDX_W-1:0] got,
		input logic [SECTOR_IDX_W-1:0] exp, input string name);
		if (got !== exp) begin
			fail_now($sformatf("FAILED %s: got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			fail_now($sformatf("FAILED %s: got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	// Column value the keyboard scan should see
	function automatic kbd_cols_t expected_cols(input kbd_rows_t rows, input kbd_cols_t cols,
		input joy_t joy);
		kbd_cols_t res;
		res = cols;
		if ((rows[6] && joy.up) || (rows[5] && joy.down) || (rows[4] && joy.right)
			|| (rows[3] && joy.left)) begin
			res[0] = 1'b1;
		end
		if (rows[7] && (joy.fire1 || joy.fire2)) begin
			res[4] = 1'b1;
		end
		return res;
	endfunction

	////////////////////////////////////////
	// Waits with a cycle limit
	////////////////////////////////////////

	task automatic wait_rd_high(input int max_cycles);
		int n;
		n = 0;
		while (sd_req_o.rd !== 1'b1) begin
			if (n >= max_cycles) begin
				fail_now($sformatf("SD read did not start within %0d cycles", max_cycles));
			end else begin
				step_cycle();
				n++;
			end
		end
	endtask

	task automatic wait_load_end(input int max_cycles);
		int n;
		n = 0;
		while (cpu_wait_o !== 1'b0) begin
			if (n >= max_cycles) begin
				fail_now($sformatf("CPU wait still high after %0d cycles", max_cycles));
			end else begin
				step_cycle();
				n++;
			end
		end
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	// Entered right after reset_s falls
	task automatic power_on_hold();
		ram_port_t cpu_req;
		int        edge_n;
		check_bit(sd_req_o.rd, 1'b0, "sd_req_o.rd");
		check_bit(cpu_wait_o, 1'b0, "cpu_wait_o");
		check_cols(kbd_cols_o, '0, "kbd_cols_o");
		check_bit(cpu_reset_o, 1'b1, "cpu_reset_o");
		for (edge_n = 1; edge_n <= HOLD_EDGES + 1; edge_n++) begin
			// CPU side keeps changing under the override
			cpu_req.addr  = 16'h1000 + 16'(edge_n * 7);
			cpu_req.wdata = 8'(edge_n * 3 + 1);
			cpu_req.we    = edge_n[0];
			cpu_ram_i     = cpu_req;
			step_cycle();
			check_bit(por_hold_o, edge_n < HOLD_EDGES, "por_hold_o");
			check_bit(cpu_reset_o, edge_n <= HOLD_EDGES, "cpu_reset_o");
			check_ram(ram_o, (edge_n < HOLD_EDGES) ? CLEAR_REQ : cpu_req, "ram_o");
		end
	endtask

	task automatic user_reset_pulse();
		int edge_n;
		step_cycle();
		user_reset_i = 1'b1;
		repeat (3) begin
			step_cycle();
			check_bit(por_hold_o, 1'b1, "por_hold_o");
			check_bit(cpu_reset_o, 1'b1, "cpu_reset_o");
			check_ram(ram_o, CLEAR_REQ, "ram_o");
		end
		user_reset_i = 1'b0;
		for (edge_n = 1; edge_n <= HOLD_EDGES + 1; edge_n++) begin
			step_cycle();
			check_bit(por_hold_o, edge_n < HOLD_EDGES, "por_hold_o");
			check_bit(cpu_reset_o, edge_n <= HOLD_EDGES, "cpu_reset_o");
			check_ram(ram_o, (edge_n < HOLD_EDGES) ? CLEAR_REQ : cpu_ram_i, "ram_o");
		end
	endtask

	task automatic joystick_merge();
		kbd_rows_t rows;
		kbd_cols_t cols;
		joy_t      joy;
		int        n;
		for (n = 0; n < 40; n++) begin
			rows       = 8'($random(seed));
			cols       = 6'($random(seed));
			joy        = 6'($random(seed));
			kbd_rows_i = rows;
			kbd_cols_i = cols;
			joy_i      = joy;
			step_cycle();
			check_cols(kbd_cols_o, expected_cols(rows, cols, joy), "kbd_cols_o");
		end
		kbd_rows_i = '0;
		kbd_cols_i = '0;
		joy_i      = '0;
	endtask

	// SD host model, one ack per sector, held 2 cycles
	task automatic run_track_load(input logic [LBA_W-1:0] first_lba);
		sd_req_t exp_req;
		int      k;
		wait_rd_high(40);
		for (k = 0; k < SECTORS_PER_TRACK; k++) begin
			exp_req.rd  = 1'b1;
			exp_req.lba = first_lba + LBA_W'(k);
			check_sd(sd_req_o, exp_req, "sd_req_o");
			check_index(sector_index_o, SECTOR_IDX_W'(k), "sector_index_o");
			check_bit(cpu_wait_o, 1'b1, "cpu_wait_o");
			sd_ack_i = 1'b1;
			step_cycle();
			step_cycle();
			// rd drops on the last sector's ack
			exp_req.rd  = (k != SECTORS_PER_TRACK - 1);
			exp_req.lba = first_lba + LBA_W'(k + 1);
			check_sd(sd_req_o, exp_req, "sd_req_o");
			check_bit(cpu_wait_o, 1'b1, "cpu_wait_o");
			sd_ack_i = 1'b0;
			step_cycle();
		end
		wait_load_end(20);
		check_bit(sd_req_o.rd, 1'b0, "sd_req_o.rd");
		check_index(sector_index_o, SECTOR_IDX_W'(SECTORS_PER_TRACK), "sector_index_o");
	endtask

	task automatic track_load();
		image_present_i = 1'b1;
		track_i         = 6'd5;
		run_track_load(LBA_W'(SECTORS_PER_TRACK * 5));
		// Same track again, no reload expected
		repeat (4) begin
			step_cycle();
			check_bit(sd_req_o.rd, 1'b0, "sd_req_o.rd");
			check_bit(cpu_wait_o, 1'b0, "cpu_wait_o");
		end
	endtask

	task automatic remount_load();
		img_mounted_i = 1'b1;
		step_cycle();
		img_mounted_i = 1'b0;
		run_track_load(LBA_W'(SECTORS_PER_TRACK * 5));
	endtask

	task automatic no_image_track_change();
		image_present_i = 1'b0;
		track_i         = 6'd9;
		repeat (20) begin
			step_cycle();
			check_bit(sd_req_o.rd, 1'b0, "sd_req_o.rd");
			check_bit(cpu_wait_o, 1'b0, "cpu_wait_o");
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		seed            = 24;
		cycle_count     = 0;
		reset_s         = 1'b1;
		user_reset_i    = 1'b0;
		cpu_ram_i       = '0;
		kbd_rows_i      = '0;
		kbd_cols_i      = '0;
		joy_i           = '0;
		track_i         = '0;
		img_mounted_i   = 1'b0;
		image_present_i = 1'b0;
		sd_ack_i        = 1'b0;
		repeat (5) begin
			step_cycle();
		end
		reset_s = 1'b0;
		power_on_hold();
		user_reset_pulse();
		joystick_merge();
		track_load();
		remount_load();
		no_image_track_change();
		step_cycle();
		// Bound assertions count their own failures
		assert_errors = u_tk2000_glue_top.u_glue_asserts.fail_count;
		if (assert_errors == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			fail_now($sformatf("%0d assertion failures during the run", assert_errors));
		end
	end

endmodule

/* tb_tk2000_glue_asserts.sv */
// Handshake and RAM override assertions for the glue top
// Sees both the track loader and the reset sequencer outputs
module tb_tk2000_glue_asserts #(
	parameter int unsigned SECTORS_PER_TRACK = 13
) (
	input logic                                   CLK_VIDEO,
	input logic                                   reset_s,
	input logic                                   load_req_i,
	input logic                                   load_ack_i,
	input core_glue_pkg::sd_req_t                 sd_req_i,
	input logic                                   sd_ack_i,
	input logic [core_glue_pkg::SECTOR_IDX_W-1:0] sector_index_i,
	input logic                                   cpu_wait_i,
	input logic                                   por_hold_i,
	input core_glue_pkg::ram_port_t               ram_i
);

	timeunit 1ns;
	timeprecision 100ps;

	import core_glue_pkg::*;

	localparam logic [SECTOR_IDX_W-1:0] LAST_SECTOR = SECTOR_IDX_W'(SECTORS_PER_TRACK - 1);
	localparam ram_port_t CLEAR_REQ = '{addr: RAM_CLEAR_ADDR, wdata: 8'h00, we: 1'b1};

	int unsigned fail_count;

	initial fail_count = 0;

	// Load done only while the request is still up
	a_ack_needs_req: assert property (@(posedge CLK_VIDEO) disable iff (reset_s)
		$rose(load_ack_i) |-> load_req_i)
	else begin
		$error("load_ack rose without load_req");
		fail_count++;
	end

	// rd falls only after the rising ack of the last sector
	a_rd_until_last: assert property (@(posedge CLK_VIDEO) disable iff (reset_s)
		$fell(sd_req_i.rd) |-> ($past(sd_ack_i) && !$past(sd_ack_i, 2)
			&& $past(sector_index_i) == LAST_SECTOR))
	else begin
		$error("SD read dropped before the last sector ack");
		fail_count++;
	end

	a_wait_idle: assert property (@(posedge CLK_VIDEO) disable iff (reset_s)
		(!sd_req_i.rd && !load_req_i && !load_ack_i) |-> !cpu_wait_i)
	else begin
		$error("CPU wait high with loader idle");
		fail_count++;
	end

	// Warm-start vector cleared during the hold
	a_ram_clear: assert property (@(posedge CLK_VIDEO) disable iff (reset_s)
		por_hold_i |-> (ram_i == CLEAR_REQ))
	else begin
		$error("RAM port not forced to the clear request during hold");
		fail_count++;
	end

endmodule

bind tk2000_glue_top tb_tk2000_glue_asserts #(
	.SECTORS_PER_TRACK (SECTORS_PER_TRACK)
) u_glue_asserts (
	.CLK_VIDEO      (CLK_VIDEO),
	.reset_s        (reset_s),
	.load_req_i     (load_req),
	.load_ack_i     (load_ack),
	.sd_req_i       (sd_req_o),
	.sd_ack_i       (sd_ack_i),
	.sector_index_i (sector_index_o),
	.cpu_wait_i     (cpu_wait_o),
	.por_hold_i     (por_hold_o),
	.ram_i          (ram_o)
);

/* tk2000_glue_top.sv */
// Glue logic top for the home-computer core
// Reset sequencer, joystick merge and floppy track loader
module tk2000_glue_top #(
	parameter int unsigned HOLD_BITS         = 23,
	parameter int unsigned SECTORS_PER_TRACK = 13
) (
	input  logic                                   CLK_VIDEO,
	input  logic                                   reset_s,
	input  logic                                   user_reset_i,
	input  core_glue_pkg::ram_port_t               cpu_ram_i,
	input  core_glue_pkg::kbd_rows_t               kbd_rows_i,
	input  core_glue_pkg::kbd_cols_t               kbd_cols_i,
	input  core_glue_pkg::joy_t                    joy_i,
	input  logic [core_glue_pkg::TRACK_W-1:0]      track_i,
	input  logic                                   img_mounted_i,
	input  logic                                   image_present_i,
	input  logic                                   sd_ack_i,
	output core_glue_pkg::ram_port_t               ram_o,
	output logic                                   por_hold_o,
	output logic                                   cpu_reset_o,
	output core_glue_pkg::kbd_cols_t               kbd_cols_o,
	output core_glue_pkg::sd_req_t                 sd_req_o,
	output logic [core_glue_pkg::SECTOR_IDX_W-1:0] sector_index_o,
	output logic                                   cpu_wait_o
);

	import core_glue_pkg::*;

	// Detector to fetcher handshake
	logic       load_req;
	logic       load_ack;
	track_req_t track_req;

	////////////////////////////////////////
	// Reset and RAM override
	////////////////////////////////////////

	reset_sequencer #(
		.HOLD_BITS (HOLD_BITS)
	) u_reset_sequencer (
		.CLK_VIDEO    (CLK_VIDEO),
		.reset_s      (reset_s),
		.user_reset_i (user_reset_i),
		.cpu_ram_i    (cpu_ram_i),
		.ram_o        (ram_o),
		.por_hold_o   (por_hold_o),
		.cpu_reset_o  (cpu_reset_o)
	);

	// Keyboard scan with joystick
	joystick_key_merge u_joystick_key_merge (
		.CLK_VIDEO  (CLK_VIDEO),
		.reset_s    (reset_s),
		.kbd_rows_i (kbd_rows_i),
		.kbd_cols_i (kbd_cols_i),
		.joy_i      (joy_i),
		.kbd_cols_o (kbd_cols_o)
	);

	////////////////////////////////////////
	// Floppy track loader
	////////////////////////////////////////

	track_change_detect u_track_change_detect (
		.CLK_VIDEO       (CLK_VIDEO),
		.reset_s         (reset_s),
		.track_i         (track_i),
		.img_mounted_i   (img_mounted_i),
		.image_present_i (image_present_i),
		.load_ack_i      (load_ack),
		.load_req_o      (load_req),
		.req_o           (track_req)
	);

	sector_fetch_sequencer #(
		.SECTORS_PER_TRACK (SECTORS_PER_TRACK)
	) u_sector_fetch_sequencer (
		.CLK_VIDEO      (CLK_VIDEO),
		.reset_s        (reset_s),
		.load_req_i     (load_req),
		.req_i          (track_req),
		.sd_ack_i       (sd_ack_i),
		.load_ack_o     (load_ack),
		.sd_req_o       (sd_req_o),
		.sector_index_o (sector_index_o),
		.cpu_wait_o     (cpu_wait_o)
	);

endmodule

/* track_change_detect.sv */
// Track change and remount detector for the floppy loader
// Issues a four-phase load request for the track under the head
module track_change_detect (
	input  logic                                 CLK_VIDEO,
	input  logic                                 reset_s,
	input  logic [core_glue_pkg::TRACK_W-1:0]    track_i,
	input  logic                                 img_mounted_i,
	input  logic                                 image_present_i,
	input  logic                                 load_ack_i,
	output logic                                 load_req_o,
	output core_glue_pkg::track_req_t            req_o
);

	import core_glue_pkg::*;

	// Last track handed to the loader
	logic [TRACK_W-1:0] last_track;
	// Mount seen since last load
	logic               mounted;
	logic               idle;
	logic               trigger;

	// Handshake fully returned to zero
	assign idle = ~load_req_o & ~load_ack_i;

	// Remount fires once the pulse has passed
	assign trigger = idle & ((track_i != last_track) | (mounted & ~img_mounted_i));

	////////////////////////////////////////
	// Request side of the handshake
	////////////////////////////////////////

	always_ff @(posedge CLK_VIDEO) begin
		if (reset_s) begin
			last_track <= '0;
			mounted    <= 1'b0;
			load_req_o <= 1'b0;
		end else begin
			if (img_mounted_i) begin
				mounted <= 1'b1;
			end else if (trigger) begin
				mounted <= 1'b0;
			end
			if (trigger) begin
				last_track <= track_i;
				// No image, just remember where the head is
				load_req_o <= image_present_i;
			end else if (load_req_o && load_ack_i) begin
				load_req_o <= 1'b0;
			end
		end
	end

	// Track stays stable while load_req is high
	assign req_o.track = last_track;

endmodule
